/* compile.f */
source/rvPkg.sv
source/controller.sv
source/alu.sv
source/regFile.sv
source/immGen.sv
source/pcUnit.sv
source/rvCore.sv
verif/tbRvCore.sv

/* run.sh */
#!/bin/sh
# build and run the testbench, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
    --top-module tbRvCore -o simv > build.log 2>&1 || { echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || grep -q "Test OK" sim.log || exit 1
exit 0

/* source/alu.sv */
module alu (
    input  logic [31:0]    a,
    input  logic [31:0]    rs2Data,
    input  logic [31:0]    imm,
    input  rvPkg::aluSrcE  aluSrc,
    input  rvPkg::aluOpE   aluOp,
    output logic [31:0]    result,
    output rvPkg::flagsT   flags
);

    logic [31:0] b;
    logic        ltS;
    logic        ltU;

    assign b = (aluSrc == rvPkg::srcImm) ? imm : rs2Data;

    assign ltS = $signed(a) < $signed(b);
    assign ltU = a < b;

    // compare flags for the branch logic
    assign flags.zero = (a == b);
    assign flags.lt   = ltS;

    always_comb begin
        case (aluOp)
            rvPkg::aluAdd:  result = a + b;
            rvPkg::aluSub:  result = a - b;
            rvPkg::aluAnd:  result = a & b;
            rvPkg::aluOr:   result = a | b;
            rvPkg::aluXor:  result = a ^ b;
            rvPkg::aluSlt:  result = {31'd0, ltS};
            rvPkg::aluSltu: result = {31'd0, ltU};
            default:        result = 32'd0;
        endcase
    end

endmodule

/* source/controller.sv */
module controller (
    input  logic               rstN,
    input  logic [31:0]        instr,
    input  rvPkg::flagsT       flags,
    output rvPkg::ctrlT        ctrl
);

    rvPkg::opcodeE opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          taken;

    assign opcode = rvPkg::opcodeE'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // branch decision, bge is the inverse of lt
    always_comb begin
        case (funct3)
            3'b000:  taken = flags.zero;
            3'b001:  taken = !flags.zero;
            3'b100:  taken = flags.lt;
            3'b101:  taken = !flags.lt;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl.regWrite  = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.pcSel     = rvPkg::pcPlus4;
        ctrl.resultSel = rvPkg::resAlu;
        ctrl.aluSrc    = rvPkg::srcReg;
        ctrl.immSel    = rvPkg::immI;
        ctrl.aluOp     = rvPkg::aluAdd;

        case (opcode)
            rvPkg::opR: begin
                ctrl.regWrite = 1'b1;
                case ({funct7, funct3})
                    10'h000: ctrl.aluOp = rvPkg::aluAdd;
                    10'h100: ctrl.aluOp = rvPkg::aluSub;
                    10'h006: ctrl.aluOp = rvPkg::aluOr;
                    10'h007: ctrl.aluOp = rvPkg::aluAnd;
                    10'h002: ctrl.aluOp = rvPkg::aluSlt;
                    10'h003: ctrl.aluOp = rvPkg::aluSltu;
                    default: ctrl.regWrite = 1'b0; // not in the subset
                endcase
            end
            rvPkg::opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = rvPkg::srcImm;
                case (funct3)
                    3'b000:  ctrl.aluOp = rvPkg::aluAdd;
                    3'b100:  ctrl.aluOp = rvPkg::aluXor;
                    3'b110:  ctrl.aluOp = rvPkg::aluOr;
                    3'b010:  ctrl.aluOp = rvPkg::aluSlt;
                    3'b011:  ctrl.aluOp = rvPkg::aluSltu;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            rvPkg::opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSel = rvPkg::resMem;
                ctrl.aluSrc    = rvPkg::srcImm;
            end
            rvPkg::opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = rvPkg::srcImm;
                ctrl.immSel   = rvPkg::immS;
            end
            rvPkg::opBranch: begin
                ctrl.immSel = rvPkg::immB;
                ctrl.aluOp  = rvPkg::aluSub; // flags from rs1 - rs2
                ctrl.pcSel  = taken ? rvPkg::pcTarget : rvPkg::pcPlus4;
            end
            rvPkg::opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSel    = rvPkg::immU;
                ctrl.resultSel = rvPkg::resImm;
            end
            rvPkg::opJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSel    = rvPkg::immJ;
                ctrl.resultSel = rvPkg::resPc4;
                ctrl.pcSel     = rvPkg::pcTarget;
            end
            rvPkg::opJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = rvPkg::srcImm;
                ctrl.resultSel = rvPkg::resPc4;
                ctrl.pcSel     = rvPkg::pcAlu;
            end
            default: ; // unknown opcode, no writes
        endcase

        if (!rstN) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

endmodule

/* source/immGen.sv */
module immGen (
    input  logic [31:0]    instr,
    input  rvPkg::immSelE  immSel,
    output logic [31:0]    imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immSel)
            rvPkg::immI: imm = {{20{sign}}, instr[31:20]};
            rvPkg::immS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            rvPkg::immB: begin
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            rvPkg::immU: imm = {instr[31:12], 12'd0}; // low bits zero
            rvPkg::immJ: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default:     imm = 32'd0;
        endcase
    end

endmodule

/* source/pcUnit.sv */
module pcUnit #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rstN,
    input  rvPkg::pcSelE  pcSel,
    input  logic [31:0]   imm,
    input  logic [31:0]   aluResult,
    output logic [31:0]   pc,
    output logic [31:0]   pcPlus4
);

    logic [31:0] nextPc;

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (pcSel)
            rvPkg::pcTarget: nextPc = pc + imm;
            rvPkg::pcAlu:    nextPc = {aluResult[31:1], 1'b0}; // jalr clears bit 0
            default:         nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

    // no misaligned fetch is handled, targets must be word aligned
    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

/* source/regFile.sv */
module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  logic [4:0]  rdAddr,
    input  logic [31:0] rdData,
    input  logic        we,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && rdAddr != 5'd0) begin // x0 stays zero
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

    // x0 is never written after reset
    assert property (@(posedge clk) disable iff (!rstN)
        (rs1Addr == 5'd0) |-> (rs1Data == 32'd0));

    assert property (@(posedge clk) disable iff (!rstN)
        (rs2Addr == 5'd0) |-> (rs2Data == 32'd0));

endmodule

/* source/rvCore.sv */
module rvCore #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rstN,
    output logic [31:0] instrAddr,
    input  logic [31:0] instr,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWdata,
    output logic        dataWe,
    input  logic [31:0] dataRdata
);

    rvPkg::ctrlT  ctrl;
    rvPkg::flagsT flags;
    logic [31:0]  imm;
    logic [31:0]  rs1Data;
    logic [31:0]  rs2Data;
    logic [31:0]  aluResult;
    logic [31:0]  pc;
    logic [31:0]  pcPlus4;
    logic [31:0]  wbData;

    controller uCtrl (
        .rstN  (rstN),
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl)
    );

    immGen uImm (
        .instr  (instr),
        .immSel (ctrl.immSel),
        .imm    (imm)
    );

    regFile uRegs (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (instr[19:15]),
        .rs2Addr (instr[24:20]),
        .rdAddr  (instr[11:7]),
        .rdData  (wbData),
        .we      (ctrl.regWrite),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    alu uAlu (
        .a       (rs1Data),
        .rs2Data (rs2Data),
        .imm     (imm),
        .aluSrc  (ctrl.aluSrc),
        .aluOp   (ctrl.aluOp),
        .result  (aluResult),
        .flags   (flags)
    );

    pcUnit #(
        .resetPc (resetPc)
    ) uPc (
        .clk       (clk),
        .rstN      (rstN),
        .pcSel     (ctrl.pcSel),
        .imm       (imm),
        .aluResult (aluResult),
        .pc        (pc),
        .pcPlus4   (pcPlus4)
    );

    // write-back select
    always_comb begin
        case (ctrl.resultSel)
            rvPkg::resMem: wbData = dataRdata;
            rvPkg::resPc4: wbData = pcPlus4;
            rvPkg::resImm: wbData = imm;
            default:       wbData = aluResult;
        endcase
    end

    assign instrAddr = pc;
    assign dataAddr  = aluResult;
    assign dataWdata = rs2Data;
    assign dataWe    = ctrl.memWrite;

    // decoder outputs checked against the fetched word
    assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl.memWrite && ctrl.regWrite));

    assert property (@(posedge clk) disable iff (!rstN)
        !(instr[6:0] inside {rvPkg::opR, rvPkg::opImm, rvPkg::opLoad, rvPkg::opStore,
                             rvPkg::opBranch, rvPkg::opLui, rvPkg::opJal, rvPkg::opJalr})
        |-> !(ctrl.regWrite || ctrl.memWrite));

endmodule

/* source/rvPkg.sv */
package rvPkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opR      = 7'd51,
        opImm    = 7'd19,
        opLoad   = 7'd3,
        opStore  = 7'd35,
        opBranch = 7'd99,
        opLui    = 7'd55,
        opJal    = 7'd111,
        opJalr   = 7'd103
    } opcodeE;

    typedef enum logic [2:0] {
        aluAdd  = 3'd0,
        aluSub  = 3'd1,
        aluAnd  = 3'd2,
        aluOr   = 3'd3,
        aluXor  = 3'd4,
        aluSlt  = 3'd5,
        aluSltu = 3'd6
    } aluOpE;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immU = 3'd3,
        immJ = 3'd4
    } immSelE;

    typedef enum logic [1:0] {
        pcPlus4  = 2'd0,
        pcTarget = 2'd1, // pc + imm
        pcAlu    = 2'd2  // jalr
    } pcSelE;

    typedef enum logic [1:0] {
        resAlu = 2'd0,
        resMem = 2'd1,
        resPc4 = 2'd2,
        resImm = 2'd3
    } resultSelE;

    typedef enum logic [1:0] {
        srcReg = 2'd0,
        srcImm = 2'd1
    } aluSrcE;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        pcSelE     pcSel;
        resultSelE resultSel;
        aluSrcE    aluSrc;
        immSelE    immSel;
        aluOpE     aluOp;
    } ctrlT;

    typedef struct packed {
        logic zero;
        logic lt;   // signed
    } flagsT;

endpackage

/* verif/tbRvCore.sv */
module tbRvCore;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk = 1'b0;
    logic        rstN = 1'b0;
    logic [31:0] instrAddr, instr, dataAddr, dataWdata, dataRdata;
    logic        dataWe;
    logic [31:0] rom [0:255];
    logic [31:0] ram [0:255];
    logic [31:0] endAddr;
    int          pIdx;
    int          errors = 0;
    int          seed = 32'h368b;

    rvCore #(.resetPc(32'h0)) dut0 (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe), .dataRdata(dataRdata)
    );

    always #10 clk = !clk;

    assign instr     = rom[instrAddr[9:2]];
    assign dataRdata = ram[dataAddr[9:2]];

    function automatic logic [31:0] fillWord(input int i);
        return (i * 32'h9e37_79b9) ^ 32'h5a5a_0000;
    endfunction

    // data RAM model refilled while reset is low
    always @(posedge clk) begin
        assert (rstN || !dataWe) else begin
            errors++;
            $display("data write seen during reset at %0t", $time);
        end
        if (!rstN) begin
            for (int i = 0; i < 256; i++) ram[i] <= fillWord(i);
        end else if (dataWe) begin
            ram[dataAddr[9:2]] <= dataWdata;
        end
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'd51};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'd35};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs1, rs2,
                                         input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'd99};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'd111};
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[pIdx] = w;
        pIdx++;
    endtask

    task automatic loadConst(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] upper;
        upper = (val + 32'h800) >> 12;
        emit({upper[19:0], rd, 7'd55});           // lui
        emit(encI(val[11:0], rd, 3'b000, rd, 7'd19)); // addi
    endtask

    task automatic storeSlot(input logic [4:0] rs, input int k);
        emit(encS(12'h200 + 12'(4 * k), rs, 5'd0));
    endtask

    task automatic startProgram();
        @(posedge clk);
        rstN <= 1'b0;
        for (int i = 0; i < 256; i++) rom[i] = 32'h0;
        pIdx = 0;
    endtask

    // close with a self-loop, release reset and wait for the loop
    task automatic runProgram();
        int cycles;
        endAddr = pIdx * 4;
        emit(encJ(21'd0, 5'd0));
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (instrAddr != endAddr && cycles < 1000) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= 1000) begin
            errors++;
            $display("timeout: program never reached its final loop at %0t", $time);
        end
    endtask

    task automatic checkWord(input int idx, input logic [31:0] exp, input string what);
        assert (ram[idx] === exp) else begin
            errors++;
            $display("ERR %0t: %s word %0d got %h expected %h", $time, what, idx, ram[idx], exp);
        end
    endtask

    task automatic testRType();
        logic [31:0] a, b, exp;
        logic [2:0]  f3s [6] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd2, 3'd3};
        a = $random(seed);
        b = $random(seed);
        startProgram();
        loadConst(1, a);
        loadConst(2, b);
        for (int k = 0; k < 6; k++) begin
            emit(encR(k == 1 ? 7'h20 : 7'h0, f3s[k], 5'd3, 5'd1, 5'd2));
            storeSlot(3, k);
        end
        runProgram();
        for (int k = 0; k < 6; k++) begin
            case (k)
                0: exp = a + b;
                1: exp = a - b;
                2: exp = a & b;
                3: exp = a | b;
                4: exp = {31'd0, $signed(a) < $signed(b)};
                default: exp = {31'd0, a < b};
            endcase
            checkWord(128 + k, exp, "R-type");
        end
    endtask

    task automatic testIType();
        logic [31:0] a, s, exp;
        logic [11:0] imms [5];
        logic [2:0]  f3s [5] = '{3'd0, 3'd4, 3'd6, 3'd2, 3'd3};
        a = $random(seed);
        for (int k = 0; k < 5; k++) imms[k] = 12'($random(seed));
        imms[0][11] = 1'b1; // negative addi
        startProgram();
        loadConst(1, a);
        for (int k = 0; k < 5; k++) begin
            emit(encI(imms[k], 5'd1, f3s[k], 5'd3, 7'd19));
            storeSlot(3, k);
        end
        runProgram();
        for (int k = 0; k < 5; k++) begin
            s = {{20{imms[k][11]}}, imms[k]};
            case (k)
                0: exp = a + s;
                1: exp = a ^ s;
                2: exp = a | s;
                3: exp = {31'd0, $signed(a) < $signed(s)};
                default: exp = {31'd0, a < s};
            endcase
            checkWord(128 + k, exp, "I-type");
        end
    endtask

    task automatic testLoadStore();
        logic [31:0] a;
        a = $random(seed);
        startProgram();
        loadConst(1, a);
        loadConst(5, 32'h180);
        emit(encS(-12'sd8, 5'd1, 5'd5));                  // sw x1, -8(x5)
        emit(encI(-12'sd8, 5'd5, 3'b010, 5'd6, 7'd3));    // lw x6, -8(x5)
        storeSlot(6, 0);
        runProgram();
        checkWord(32'h178 >> 2, a, "store");
        checkWord(128, a, "load");
    endtask

    task automatic testBranches();
        logic [31:0] lo, hi, a, b, mark;
        logic [2:0]  f3s [4] = '{3'd0, 3'd1, 3'd4, 3'd5};
        logic        taken [12];
        lo = 32'h8000_0000 | $random(seed);
        hi = 32'h7fff_ffff & $random(seed);
        mark = 32'h1234_5678;
        startProgram();
        loadConst(7, mark);
        for (int k = 0; k < 12; k++) begin
            a = (k % 3 == 2) ? hi : ((k % 3 == 1) ? lo : hi);
            b = (k % 3 == 2) ? lo : hi;
            case (f3s[k / 3])
                3'd0: taken[k] = (a == b);
                3'd1: taken[k] = (a != b);
                3'd4: taken[k] = $signed(a) < $signed(b);
                default: taken[k] = !($signed(a) < $signed(b));
            endcase
            loadConst(1, a);
            loadConst(2, b);
            emit(encB(13'd8, 5'd1, 5'd2, f3s[k / 3]));
            storeSlot(7, k); // marker skipped when taken
        end
        runProgram();
        for (int k = 0; k < 12; k++) checkWord(128 + k, taken[k] ? fillWord(128 + k) : mark,
                                               "branch marker");
    endtask

    task automatic testJumps();
        logic [31:0] mark, jalAt, jalrAt, tgt;
        mark = 32'hcafe_0001;
        startProgram();
        loadConst(7, mark);
        jalAt = pIdx * 4;
        emit(encJ(21'd8, 5'd8));
        storeSlot(7, 0);     // skipped
        storeSlot(8, 1);
        storeSlot(7, 2);
        tgt = (pIdx + 4) * 4;
        loadConst(11, tgt + 1); // odd target drops bit 0
        jalrAt = pIdx * 4;
        emit(encI(12'd0, 5'd11, 3'b000, 5'd12, 7'd103));
        storeSlot(7, 3);     // skipped
        storeSlot(12, 4);
        storeSlot(7, 5);
        runProgram();
        checkWord(128, fillWord(128), "jal skip");
        checkWord(129, jalAt + 4, "jal link");
        checkWord(130, mark, "jal target");
        checkWord(131, fillWord(131), "jalr skip");
        checkWord(132, jalrAt + 4, "jalr link");
        checkWord(133, mark, "jalr target");
    endtask

    task automatic testIllegal();
        startProgram();
        storeSlot(0, 0);                                 // store sits at the reset PC
        emit(32'hffff_ffff);                             // unknown opcode
        emit(encI(12'd123, 5'd0, 3'b000, 5'd0, 7'd19));  // addi x0, x0, 123
        storeSlot(0, 0);
        runProgram();
        for (int i = 0; i < 256; i++) checkWord(i, i == 128 ? 32'h0 : fillWord(i), "illegal");
    endtask

    initial begin
        rstN <= 1'b0;
        testRType();
        testIType();
        testLoadStore();
        testBranches();
        testJumps();
        testIllegal();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
